/* src.f */
src/bridge_pkg.sv
src/cont_pkg.sv
src/controller_capture.sv
src/controller_slot.sv
src/bridge_regs.sv
src/controller_core_top.sv
testbench/tb_controller_core.sv

/* src/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

    //////////////////////////////
    // bus types

    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // byte offset inside the 256 byte register window
    typedef logic [7:0] bridge_off_t;

    // one bridge request as seen by the register block
    typedef struct packed {
        bridge_addr_t addr;
        logic         rd;
        logic         wr;
        bridge_data_t wr_data;
    } bridge_req_t;

    //////////////////////////////
    // register map

    // word offsets inside one slot window
    localparam bridge_off_t reg_key     = 8'h00;
    localparam bridge_off_t reg_joy     = 8'h04;
    localparam bridge_off_t reg_trig    = 8'h08;
    localparam bridge_off_t reg_press   = 8'h0C;
    localparam bridge_off_t reg_release = 8'h10;
    localparam bridge_off_t reg_frames  = 8'h14;

    localparam bridge_off_t slot_stride = 8'h20;

    // slot count word, just past the last slot window
    localparam bridge_off_t reg_info    = 8'h80;

endpackage

`default_nettype wire

/* src/bridge_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module bridge_regs import bridge_pkg::*, cont_pkg::*; #(
    parameter bridge_addr_t bridge_base = 32'h2000_0000
) (
    input  logic         clk_74a,
    input  logic         rst_n,
    input  bridge_req_t  req,
    input  cont_status_t status [num_cont],
    output bridge_data_t rd_data,
    output cont_btn_t    clr_press [num_cont],
    output cont_btn_t    clr_release [num_cont]
);

    localparam int stride_lsb = $clog2(slot_stride);

    logic                  in_win;
    bridge_off_t           win_off;
    bridge_off_t           reg_off;
    logic [7-stride_lsb:0] slot_idx;
    bridge_data_t          rd_mux;

    // pick one field of a slot, narrow ones zero extended
    function automatic bridge_data_t field_sel(cont_status_t st, bridge_off_t off);
        bridge_data_t val;
        case (off)
            reg_key:     val = st.state.key;
            reg_joy:     val = st.state.joy;
            reg_trig:    val = {16'd0, st.state.trig};
            reg_press:   val = {16'd0, st.pressed};
            reg_release: val = {16'd0, st.released};
            reg_frames:  val = {16'd0, st.frames};
            default:     val = '0;
        endcase
        return val;
    endfunction

    //////////////////////////////
    // address decode

    // base sits on a 256 byte boundary
    assign in_win   = (req.addr[31:8] == bridge_base[31:8]);
    assign win_off  = req.addr[7:0];
    assign reg_off  = win_off & (slot_stride - 8'd1);
    assign slot_idx = win_off[7:stride_lsb];

    //////////////////////////////
    // read path

    // anything outside the map reads as zero
    always_comb begin
        rd_mux = '0;
        if (in_win) begin
            if (win_off == reg_info) begin
                rd_mux = {24'd0, 8'(num_cont)};
            end
            for (int i = 0; i < num_cont; i++) begin
                if (slot_idx == i) begin
                    rd_mux = field_sel(status[i], reg_off);
                end
            end
        end
    end

    // held until the next read strobe
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (req.rd) begin
            rd_data <= rd_mux;
        end
    end

    //////////////////////////////
    // write one to clear

    // masks live for a single cycle
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_cont; i++) begin
                clr_press[i]   <= '0;
                clr_release[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_cont; i++) begin
                clr_press[i]   <= '0;
                clr_release[i] <= '0;
                if (req.wr && in_win && slot_idx == i) begin
                    if (reg_off == reg_press) begin
                        clr_press[i] <= req.wr_data[15:0];
                    end
                    if (reg_off == reg_release) begin
                        clr_release[i] <= req.wr_data[15:0];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/cont_pkg.sv */
`default_nettype none

package cont_pkg;

    // one slot per controller port group on the top
    localparam int num_cont = 4;

    // button bitmap, bit 0 first
    //   dpad up, down, left, right
    //   face a, b, x, y
    //   l1, r1, l2, r2, l3, r3
    //   select, start
    typedef logic [15:0] cont_btn_t;

    //////////////////////////////
    // raw controller words

    // key word; cont_type is the 4 bit type field at the top
    typedef struct packed {
        logic [3:0]  cont_type;
        logic [11:0] reserved;
        cont_btn_t   buttons;
    } cont_key_t;

    // analog sticks, unsigned
    typedef struct packed {
        logic [7:0] rstick_y;
        logic [7:0] rstick_x;
        logic [7:0] lstick_y;
        logic [7:0] lstick_x;
    } cont_joy_t;

    // analog triggers, unsigned
    typedef struct packed {
        logic [7:0] rtrig;
        logic [7:0] ltrig;
    } cont_trig_t;

    //////////////////////////////
    // slot types

    // one controller as sampled at vblank
    typedef struct packed {
        cont_key_t  key;
        cont_joy_t  joy;
        cont_trig_t trig;
    } cont_state_t;

    // what a slot presents to the register block
    typedef struct packed {
        cont_state_t state;
        cont_btn_t   pressed;
        cont_btn_t   released;
        cont_btn_t   frames;
    } cont_status_t;

endpackage

`default_nettype wire

/* src/controller_capture.sv */
`timescale 1ns/100ps
`default_nettype none

module controller_capture import cont_pkg::*; (
    input  logic        clk_74a,
    input  logic        rst_n,
    input  logic        vblank,
    input  cont_state_t raw [num_cont],
    output logic        sample,
    output cont_state_t frame [num_cont]
);

    logic vb_meta;
    logic vb_sync;
    logic vb_last;
    logic vb_rise;

    //////////////////////////////
    // vblank synchronizer

    // dock vblank is not related to clk_74a
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            vb_meta <= 1'b0;
            vb_sync <= 1'b0;
        end else begin
            vb_meta <= vblank;
            vb_sync <= vb_meta;
        end
    end

    // edge flop
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            vb_last <= 1'b0;
        end else begin
            vb_last <= vb_sync;
        end
    end

    assign vb_rise = vb_sync & ~vb_last;

    //////////////////////////////
    // frame snapshot

    // one cycle strobe, lines up with the new frame
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            sample <= 1'b0;
        end else begin
            sample <= vb_rise;
        end
    end

    // all ports copied on the same edge
    // so software never sees a mix of two frames
    always_ff @(posedge clk_74a) begin
        if (vb_rise) begin
            for (int i = 0; i < num_cont; i++) begin
                frame[i] <= raw[i];
            end
        end
    end

endmodule

`default_nettype wire

/* src/controller_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module controller_core_top import bridge_pkg::*, cont_pkg::*; #(
    parameter bridge_addr_t bridge_base = 32'h2000_0000
) (
    input  logic         clk_74a,
    input  logic         rst_n,

    // dock vblank, asynchronous
    input  logic         vblank,

    // controller ports, synchronous to clk_74a
    input  logic [31:0]  cont1_key,
    input  logic [31:0]  cont2_key,
    input  logic [31:0]  cont3_key,
    input  logic [31:0]  cont4_key,
    input  logic [31:0]  cont1_joy,
    input  logic [31:0]  cont2_joy,
    input  logic [31:0]  cont3_joy,
    input  logic [31:0]  cont4_joy,
    input  logic [15:0]  cont1_trig,
    input  logic [15:0]  cont2_trig,
    input  logic [15:0]  cont3_trig,
    input  logic [15:0]  cont4_trig,

    // bridge bus
    input  bridge_addr_t bridge_addr,
    input  logic         bridge_rd,
    input  logic         bridge_wr,
    input  bridge_data_t bridge_wr_data,
    output bridge_data_t bridge_rd_data
);

    bridge_req_t  bridge_req;
    cont_state_t  raw [num_cont];
    cont_state_t  frame [num_cont];
    logic         sample;
    cont_status_t status [num_cont];
    cont_btn_t    clr_press [num_cont];
    cont_btn_t    clr_release [num_cont];

    //////////////////////////////
    // port packing

    assign raw[0] = '{key: cont1_key, joy: cont1_joy, trig: cont1_trig};
    assign raw[1] = '{key: cont2_key, joy: cont2_joy, trig: cont2_trig};
    assign raw[2] = '{key: cont3_key, joy: cont3_joy, trig: cont3_trig};
    assign raw[3] = '{key: cont4_key, joy: cont4_joy, trig: cont4_trig};

    assign bridge_req = '{
        addr:    bridge_addr,
        rd:      bridge_rd,
        wr:      bridge_wr,
        wr_data: bridge_wr_data
    };

    //////////////////////////////
    // capture, slots, registers

    controller_capture u_capture (
        .clk_74a (clk_74a),
        .rst_n   (rst_n),
        .vblank  (vblank),
        .raw     (raw),
        .sample  (sample),
        .frame   (frame)
    );

    for (genvar i = 0; i < num_cont; i++) begin : g_slot
        controller_slot u_slot (
            .clk_74a     (clk_74a),
            .rst_n       (rst_n),
            .sample      (sample),
            .frame_in    (frame[i]),
            .clr_press   (clr_press[i]),
            .clr_release (clr_release[i]),
            .status      (status[i])
        );
    end

    bridge_regs #(
        .bridge_base (bridge_base)
    ) u_regs (
        .clk_74a     (clk_74a),
        .rst_n       (rst_n),
        .req         (bridge_req),
        .status      (status),
        .rd_data     (bridge_rd_data),
        .clr_press   (clr_press),
        .clr_release (clr_release)
    );

endmodule

`default_nettype wire

/* src/controller_slot.sv */
`timescale 1ns/100ps
`default_nettype none

module controller_slot import cont_pkg::*; (
    input  logic         clk_74a,
    input  logic         rst_n,
    input  logic         sample,
    input  cont_state_t  frame_in,
    input  cont_btn_t    clr_press,
    input  cont_btn_t    clr_release,
    output cont_status_t status
);

    cont_state_t state_q;
    cont_btn_t   press_q;
    cont_btn_t   release_q;
    cont_btn_t   frames_q;
    cont_btn_t   btn_rise;
    cont_btn_t   btn_fall;

    //////////////////////////////
    // button edges

    // new frame against the stored one
    // zero whenever no sample is taken
    always_comb begin
        btn_rise = '0;
        btn_fall = '0;
        if (sample) begin
            btn_rise = frame_in.key.buttons & ~state_q.key.buttons;
            btn_fall = ~frame_in.key.buttons & state_q.key.buttons;
        end
    end

    //////////////////////////////
    // frame state

    // cleared state means all buttons released
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= '0;
            frames_q <= '0;
        end else if (sample) begin
            state_q  <= frame_in;
            // free running, wraps at 16 bits
            frames_q <= frames_q + 16'd1;
        end
    end

    //////////////////////////////
    // sticky latches

    // a new edge wins over a clear of the same bit
    always_ff @(posedge clk_74a or negedge rst_n) begin
        if (!rst_n) begin
            press_q   <= '0;
            release_q <= '0;
        end else begin
            press_q   <= (press_q & ~clr_press) | btn_rise;
            release_q <= (release_q & ~clr_release) | btn_fall;
        end
    end

    assign status = '{
        state:    state_q,
        pressed:  press_q,
        released: release_q,
        frames:   frames_q
    };

endmodule

`default_nettype wire

/* testbench/controller_trace.txt */
# set slot key joy trig | rand slot key | frame | write addr data
# read addr expected name | key slot expected name | joy slot name | trig slot name
read 2000002c 00000000 reset_press1
read 20000074 00000000 reset_frames3
read 20000080 00000004 info_count
set 0 10000011 11223344 5566
set 1 20000002 a1b2c3d4 e5f6
rand 2 30000104
rand 3 40008000
frame
key 1 20000002 key1_f1
read 20000028 0000e5f6 trig1_f1
joy 2 joy2_f1
trig 3 trig3_f1
set 0 10000012 00000000 0000
key 0 10000011 key0_no_vblank
frame
read 20000010 00000001 release0_f2
frame
read 2000000c 00000013 press0_sticky
write 2000000c 00000001
read 2000000c 00000012 press0_clr
read 2000004c 00000104 press2_kept
write 20000000 ffffffff
key 0 10000012 key0_ro
read 20000074 00000003 frames3
read 20000084 00000000 unmapped_info
read 20000100 00000000 outside_win

/* testbench/tb_controller_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_controller_core import bridge_pkg::*, cont_pkg::*; ();

    localparam bridge_addr_t base_addr = 32'h2000_0000;
    localparam int clk_half = 50;
    localparam int drive_dly = 10;
    localparam int cycles_per_line = 20;
    localparam trace_path = "testbench/controller_trace.txt";

    logic         clk_74a;
    logic         rst_n;
    logic         vblank;
    cont_key_t    key_in [num_cont];
    cont_joy_t    joy_in [num_cont];
    cont_trig_t   trig_in [num_cont];
    bridge_addr_t bridge_addr;
    logic         bridge_rd;
    logic         bridge_wr;
    bridge_data_t bridge_wr_data;
    bridge_data_t bridge_rd_data;

    // joy and trig as captured by the last vblank
    cont_joy_t    joy_seen [num_cont];
    cont_trig_t   trig_seen [num_cont];
    logic [31:0]  lfsr_state;
    int           trace_lines;

    controller_core_top #(
        .bridge_base (base_addr)
    ) u_dut (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .vblank         (vblank),
        .cont1_key      (key_in[0]),
        .cont2_key      (key_in[1]),
        .cont3_key      (key_in[2]),
        .cont4_key      (key_in[3]),
        .cont1_joy      (joy_in[0]),
        .cont2_joy      (joy_in[1]),
        .cont3_joy      (joy_in[2]),
        .cont4_joy      (joy_in[3]),
        .cont1_trig     (trig_in[0]),
        .cont2_trig     (trig_in[1]),
        .cont3_trig     (trig_in[2]),
        .cont4_trig     (trig_in[3]),
        .bridge_addr    (bridge_addr),
        .bridge_rd      (bridge_rd),
        .bridge_wr      (bridge_wr),
        .bridge_wr_data (bridge_wr_data),
        .bridge_rd_data (bridge_rd_data)
    );

    initial clk_74a = 1'b0;
    always #clk_half clk_74a = ~clk_74a;

    //////////////////////////////
    // checks

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input bridge_data_t exp, input bridge_data_t act);
        if (act !== exp) begin
            abort_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_key(input string name, input cont_key_t exp, input cont_key_t act);
        if (act.cont_type !== exp.cont_type) begin
            abort_run($sformatf("error: %s type expected %h actual %h",
                                name, exp.cont_type, act.cont_type));
        end
        if (act.reserved !== exp.reserved) begin
            abort_run($sformatf("error: %s reserved expected %h actual %h",
                                name, exp.reserved, act.reserved));
        end
        if (act.buttons !== exp.buttons) begin
            abort_run($sformatf("error: %s buttons expected %h actual %h",
                                name, exp.buttons, act.buttons));
        end
    endtask

    task automatic need_fields(input int got_n, input int want_n, input string line);
        if (got_n != want_n) begin
            abort_run($sformatf("trace line has the wrong number of fields: %s", line));
        end
    endtask

    //////////////////////////////
    // stimulus

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
        end
        return bits;
    endfunction

    function automatic bridge_addr_t slot_addr(input int slot, input bridge_off_t off);
        return base_addr + slot * slot_stride + off;
    endfunction

    task automatic set_inputs(input int slot, input cont_key_t key, input cont_joy_t joy,
                              input cont_trig_t trig);
        @(posedge clk_74a);
        #drive_dly;
        key_in[slot]  = key;
        joy_in[slot]  = joy;
        trig_in[slot] = trig;
    endtask

    // all four ports are snapshotted on the vblank rise
    task automatic pulse_vblank();
        @(posedge clk_74a);
        #drive_dly;
        vblank = 1'b1;
        for (int i = 0; i < num_cont; i++) begin
            joy_seen[i]  = joy_in[i];
            trig_seen[i] = trig_in[i];
        end
        repeat (2) @(posedge clk_74a);
        #drive_dly;
        vblank = 1'b0;
        repeat (8) @(posedge clk_74a);
    endtask

    task automatic read_reg(input bridge_addr_t addr, output bridge_data_t data);
        @(posedge clk_74a);
        #drive_dly;
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(posedge clk_74a);
        #drive_dly;
        bridge_rd = 1'b0;
        data      = bridge_rd_data;
    endtask

    task automatic write_reg(input bridge_addr_t addr, input bridge_data_t data);
        @(posedge clk_74a);
        #drive_dly;
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(posedge clk_74a);
        #drive_dly;
        bridge_wr = 1'b0;
    endtask

    // writing ones to both latches of every slot leaves them empty
    task automatic clear_latches();
        bridge_data_t got;
        for (int i = 0; i < num_cont; i++) begin
            write_reg(slot_addr(i, reg_release), 32'h0000_ffff);
            read_reg(slot_addr(i, reg_release), got);
            check_data($sformatf("release%0d_clr_all", i), '0, got);
            write_reg(slot_addr(i, reg_press), 32'h0000_ffff);
            read_reg(slot_addr(i, reg_press), got);
            check_data($sformatf("press%0d_clr_all", i), '0, got);
        end
    endtask

    //////////////////////////////
    // trace player

    initial begin : run_trace
        int           fd;
        int           n;
        int           count;
        int           slot;
        string        line;
        string        op;
        string        name;
        logic [31:0]  addr;
        logic [31:0]  val;
        logic [31:0]  joy_val;
        logic [15:0]  trig_val;
        bridge_data_t got;

        rst_n          = 1'b0;
        vblank         = 1'b0;
        bridge_addr    = '0;
        bridge_rd      = 1'b0;
        bridge_wr      = 1'b0;
        bridge_wr_data = '0;
        for (int i = 0; i < num_cont; i++) begin
            key_in[i]    = '0;
            joy_in[i]    = '0;
            trig_in[i]   = '0;
            joy_seen[i]  = '0;
            trig_seen[i] = '0;
        end
        lfsr_state = 32'h2c56ef02;
        count      = 0;

        // first pass only counts lines for the watchdog
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            abort_run("cannot open the trace file testbench/controller_trace.txt");
        end
        while ($fgets(line, fd) > 0) begin
            count++;
        end
        $fclose(fd);
        if (count == 0) begin
            abort_run("the trace file holds no lines");
        end
        trace_lines = count;

        repeat (2) @(posedge clk_74a);
        #drive_dly;
        rst_n = 1'b1;

        fd = $fopen(trace_path, "r");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s", op);
            if (op == "set") begin
                n = $sscanf(line, "%s %d %h %h %h", op, slot, val, joy_val, trig_val);
                need_fields(n, 5, line);
                set_inputs(slot, val, joy_val, trig_val);
            end else if (op == "rand") begin
                n = $sscanf(line, "%s %d %h", op, slot, val);
                need_fields(n, 3, line);
                joy_val  = take_bits(32);
                trig_val = take_bits(16);
                set_inputs(slot, val, joy_val, trig_val);
            end else if (op == "frame") begin
                pulse_vblank();
            end else if (op == "write") begin
                n = $sscanf(line, "%s %h %h", op, addr, val);
                need_fields(n, 3, line);
                write_reg(addr, val);
            end else if (op == "read") begin
                n = $sscanf(line, "%s %h %h %s", op, addr, val, name);
                need_fields(n, 4, line);
                read_reg(addr, got);
                check_data(name, val, got);
            end else if (op == "key") begin
                n = $sscanf(line, "%s %d %h %s", op, slot, val, name);
                need_fields(n, 4, line);
                read_reg(slot_addr(slot, reg_key), got);
                check_key(name, val, got);
            end else if (op == "joy") begin
                n = $sscanf(line, "%s %d %s", op, slot, name);
                need_fields(n, 3, line);
                read_reg(slot_addr(slot, reg_joy), got);
                check_data(name, joy_seen[slot], got);
            end else if (op == "trig") begin
                n = $sscanf(line, "%s %d %s", op, slot, name);
                need_fields(n, 3, line);
                read_reg(slot_addr(slot, reg_trig), got);
                check_data(name, {16'd0, trig_seen[slot]}, got);
            end else begin
                abort_run($sformatf("unknown operation in the trace file: %s", op));
            end
        end
        $fclose(fd);
        clear_latches();
        $display("TB PASSED");
        $finish;
    end

    // budget grows with the trace length and the closing latch sweep
    initial begin : watchdog
        int budget;
        wait (trace_lines > 0);
        budget = (trace_lines + 4 * num_cont) * cycles_per_line;
        repeat (budget) @(posedge clk_74a);
        abort_run($sformatf("timeout: the trace did not finish within %0d cycles", budget));
    end

endmodule

`default_nettype wire
